// ==== aembDp.f ====
aembDpPkg.sv
regBank.sv
memStage.sv
axilMaster.sv
dataRam.sv
aembDpTop.sv
tbChecker.sv
tbAembDp.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing
TOP      = tbAembDp
FILELIST = aembDp.f
LOG      = sim.log

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean

// ==== tbAembDp.sv ====
`default_nettype none

module tbAembDp;

   localparam int N_RAND  = 400;
   localparam int N_FILL  = 64;
   localparam int N_TESTS = 2 + N_RAND / 50;
   // 20 cycles per command, 40 per register sweep, plus the clear
   localparam int WATCH_CYCLES = (N_RAND + 2 * N_FILL + 31) * 20 + N_TESTS * 40 + 100;

   logic           gclk;
   logic           grst;
   aembDpPkg::cmdT cmd;
   logic           cmdValid;
   logic           cmdReady;
   logic [4:0]     rdAddr;
   logic [31:0]    rdData;
   logic           sweepOn;
   logic [3:0]     testNo;
   int             errCnt;
   int             testCnt;
   int             failCnt;
   integer         seed = 10407;

   aembDpTop #(.RAM_WORDS(256)) i_dut (
      .gclk(gclk), .grst(grst), .cmd_i(cmd), .cmdValid_i(cmdValid),
      .cmdReady_o(cmdReady), .rdAddr_i(rdAddr), .rdData_o(rdData)
   );

   tbChecker i_chk (
      .gclk(gclk), .grst(grst), .cmd_i(cmd), .cmdValid_i(cmdValid),
      .cmdReady_i(cmdReady), .rdAddr_i(rdAddr), .rdData_i(rdData),
      .sweepOn_i(sweepOn), .testNo_i(testNo), .errCnt_o(errCnt),
      .testCnt_o(testCnt), .failCnt_o(failCnt)
   );

   initial begin
      gclk = 1'b0;
      forever #10 gclk = ~gclk;
   end

   initial begin
      repeat (WATCH_CYCLES) @(posedge gclk);
      $display("run timed out after %0d cycles without finishing the tests", WATCH_CYCLES);
      $display("TESTS FAILED");
      $finish;
   end

   // pattern seeded by the whole byte address
   function automatic logic [31:0] fillPat(input logic [31:0] addr);
      return (addr * 32'h0100_0193) ^ {addr[15:0], addr[31:16]} ^ 32'h5A3C_96E1;
   endfunction

   // called right after a falling edge, returns after the one where it was taken
   task automatic sendCmd(input aembDpPkg::opT op, input aembDpPkg::sizeT size,
                          input logic [4:0] rd, input logic [31:0] value);
      cmd.op    = op;
      cmd.size  = size;
      cmd.rd    = rd;
      cmd.value = value;
      cmdValid  = 1'b1;
      while (!cmdReady) begin
         @(negedge gclk);
      end
      @(negedge gclk);
      cmdValid = 1'b0;
   endtask

   task automatic sendRandom();
      aembDpPkg::opT op;
      logic [31:0]   sz;
      logic [31:0]   value;
      logic [4:0]    rd;
      op    = aembDpPkg::opT'(2'($random(seed)));
      sz    = ($random(seed) & 32'h7fff_ffff) % 3;
      rd    = 5'($random(seed));
      value = $random(seed);
      if (op == aembDpPkg::OP_LOAD || op == aembDpPkg::OP_STORE) begin
         value = {24'd0, value[7:0]};   // stay inside the 64-word window
      end
      sendCmd(op, aembDpPkg::sizeT'(sz[1:0]), rd, value);
   endtask

   task automatic sweepRegs(input logic [3:0] tNo);
      int k;
      while (!cmdReady) begin
         @(negedge gclk);
      end
      @(negedge gclk);   // a pending ALU or link write commits here
      testNo = tNo;
      for (k = 0; k < 32; k++) begin
         rdAddr  = 5'(k);
         sweepOn = 1'b1;
         @(negedge gclk);
      end
      sweepOn = 1'b0;
      @(negedge gclk);
   endtask

   initial begin
      int w;
      int i;
      int n;
      grst     = 1'b1;
      cmd      = '0;
      cmdValid = 1'b0;
      rdAddr   = 5'd0;
      sweepOn  = 1'b0;
      testNo   = 4'd0;
      repeat (2) @(posedge gclk);
      @(negedge gclk);
      grst = 1'b0;
      sweepRegs(4'd0);
      // every store follows the ALU write of its source, so it needs forwarding
      for (w = 0; w < N_FILL; w++) begin
         sendCmd(aembDpPkg::OP_ALU, aembDpPkg::SZ_WORD, 5'd1, fillPat(32'(w * 4)));
         sendCmd(aembDpPkg::OP_STORE, aembDpPkg::SZ_WORD, 5'd1, 32'(w * 4));
      end
      for (i = 1; i < 32; i++) begin
         sendCmd(aembDpPkg::OP_LOAD, aembDpPkg::SZ_WORD, 5'(i), 32'((i - 1) * 8));
      end
      sweepRegs(4'd1);
      for (n = 0; n < N_RAND; n++) begin
         sendRandom();
         if ((n + 1) % 50 == 0) begin
            sweepRegs(4'(2 + n / 50));
         end
      end
      repeat (2) @(negedge gclk);
      $display("tests run %0d, tests failing %0d, mismatches %0d", testCnt, failCnt, errCnt);
      if (errCnt == 0 && testCnt == N_TESTS) begin
         $display("TESTS PASSED");
      end else begin
         if (testCnt != N_TESTS) begin
            $display("only %0d of %0d tests were reported", testCnt, N_TESTS);
         end
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== tbChecker.sv ====
`default_nettype none

module tbChecker (
   input  wire logic           gclk,
   input  wire logic           grst,
   input  wire aembDpPkg::cmdT cmd_i,
   input  wire logic           cmdValid_i,
   input  wire logic           cmdReady_i,
   input  wire logic [4:0]     rdAddr_i,
   input  wire logic [31:0]    rdData_i,
   input  wire logic           sweepOn_i,
   input  wire logic [3:0]     testNo_i,
   output int                  errCnt_o,
   output int                  testCnt_o,
   output int                  failCnt_o
);

   logic [31:0] mReg [32];   // architectural register contents
   logic [31:0] mMem [64];   // the 64-word window the commands address
   logic [31:0] wv;
   logic [31:0] src;
   logic [5:0]  idx;
   logic [1:0]  lane;
   int          clrCycles;
   int          testErrs;
   logic        inTest;

   function automatic string testName(input logic [3:0] n);
      string s;
      if (n == 4'd0) begin
         s = "clear";
      end else if (n == 4'd1) begin
         s = "fill";
      end else begin
         s = $sformatf("random%0d", n - 4'd1);
      end
      return s;
   endfunction

   always @(posedge gclk) begin
      if (grst) begin
         for (int k = 0; k < 32; k++) begin
            mReg[k] = 32'd0;
         end
         clrCycles = 0;
         testErrs  = 0;
         inTest    = 1'b0;
         errCnt_o  = 0;
         testCnt_o = 0;
         failCnt_o = 0;
      end else begin
         if (clrCycles < 32) begin
            clrCycles++;   // the bank clears r0..r31 one per cycle
            if (cmdReady_i) begin
               $display("clear: command port was ready before the register clear finished");
               testErrs++;
               errCnt_o++;
            end
         end
         if (cmdValid_i && cmdReady_i) begin
            idx  = cmd_i.value[7:2];
            lane = cmd_i.value[1:0];
            src  = mReg[cmd_i.rd];
            wv   = mMem[idx];
            case (cmd_i.op)
               aembDpPkg::OP_ALU: wv = cmd_i.value;
               aembDpPkg::OP_LINK: wv = {cmd_i.value[31:2], 2'b00};
               aembDpPkg::OP_LOAD: begin
                  if (cmd_i.size == aembDpPkg::SZ_BYTE) begin
                     wv = {24'd0, wv[{lane, 3'b000} +: 8]};
                  end else if (cmd_i.size == aembDpPkg::SZ_HALF) begin
                     wv = {16'd0, wv[{lane[1], 4'b0000} +: 16]};
                  end
               end
               default: begin
                  if (cmd_i.size == aembDpPkg::SZ_BYTE) begin
                     mMem[idx][{lane, 3'b000} +: 8] = src[7:0];
                  end else if (cmd_i.size == aembDpPkg::SZ_HALF) begin
                     mMem[idx][{lane[1], 4'b0000} +: 16] = src[15:0];
                  end else begin
                     mMem[idx] = src;
                  end
               end
            endcase
            if (cmd_i.op != aembDpPkg::OP_STORE && cmd_i.rd != 5'd0) begin
               mReg[cmd_i.rd] = wv;
            end
         end
         if (sweepOn_i) begin
            inTest = 1'b1;
            if (rdData_i !== mReg[rdAddr_i]) begin
               $display("ERR %s r%0d expected %08h actual %08h", testName(testNo_i),
                        rdAddr_i, mReg[rdAddr_i], rdData_i);
               testErrs++;
               errCnt_o++;
            end
         end else if (inTest) begin
            $display("test %s %s, %0d mismatches", testName(testNo_i),
                     (testErrs == 0) ? "ok" : "failing", testErrs);
            testCnt_o++;
            if (testErrs != 0) begin
               failCnt_o++;
            end
            testErrs = 0;
            inTest   = 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

// ==== aembDpTop.sv ====
`default_nettype none

module aembDpTop #(
   parameter int RAM_WORDS = 256
) (
   input  wire logic           gclk,
   input  wire logic           grst,
   input  wire aembDpPkg::cmdT cmd_i,
   input  wire logic           cmdValid_i,
   output logic                cmdReady_o,
   input  wire logic [4:0]     rdAddr_i,
   output logic [31:0]         rdData_o
);

   wire logic               wEn;
   wire logic [4:0]         wAddr;
   wire aembDpPkg::wbSelT   wbSel;
   wire logic [31:0]        result;
   wire logic [31:2]        pcLink;
   wire logic [3:0]         dwbSel;
   wire logic [4:0]         stAddr;
   wire aembDpPkg::sizeT    sizeSel;
   wire logic               gena;
   wire aembDpPkg::busWordT storeData;
   wire aembDpPkg::busWordT loadWord;
   wire aembDpPkg::axiReqT  req;
   wire logic               reqValid;
   wire logic               reqReady;
   wire logic               done;
   wire aembDpPkg::axiBusT  mstBus;
   wire aembDpPkg::axiBusT  slvBus;
   wire logic               awvalid, awready, wvalid, wready, bvalid, bready;
   wire logic               arvalid, arready, rvalid, rready;

   memStage #(.RAM_WORDS(RAM_WORDS)) i_mem (
      .gclk(gclk), .grst(grst), .cmd_i(cmd_i), .cmdValid_i(cmdValid_i),
      .cmdReady_o(cmdReady_o), .wEn_o(wEn), .wAddr_o(wAddr), .wbSel_o(wbSel),
      .result_o(result), .pcLink_o(pcLink), .dwbSel_o(dwbSel), .stAddr_o(stAddr),
      .size_o(sizeSel), .gena_o(gena), .storeData_i(storeData), .req_o(req),
      .reqValid_o(reqValid), .reqReady_i(reqReady), .done_i(done)
   );

   regBank i_regf (
      .gclk(gclk), .grst(grst), .gena_i(gena), .wEn_i(wEn), .wAddr_i(wAddr),
      .wbSel_i(wbSel), .result_i(result), .pcLink_i(pcLink), .busRd_i(loadWord),
      .dwbSel_i(dwbSel), .size_i(sizeSel), .stAddr_i(stAddr), .rdAddr_i(rdAddr_i),
      .rdData_o(rdData_o), .storeData_o(storeData)
   );

   axilMaster i_axm (
      .gclk(gclk), .grst(grst), .req_i(req), .reqValid_i(reqValid),
      .reqReady_o(reqReady), .done_o(done), .rdata_o(loadWord), .axiM_o(mstBus),
      .axiS_i(slvBus), .awvalid_o(awvalid), .awready_i(awready), .wvalid_o(wvalid),
      .wready_i(wready), .bvalid_i(bvalid), .bready_o(bready), .arvalid_o(arvalid),
      .arready_i(arready), .rvalid_i(rvalid), .rready_o(rready)
   );

   dataRam #(.RAM_WORDS(RAM_WORDS)) i_ram (
      .gclk(gclk), .grst(grst), .axiM_i(mstBus), .axiS_o(slvBus),
      .awvalid_i(awvalid), .awready_o(awready), .wvalid_i(wvalid), .wready_o(wready),
      .bvalid_o(bvalid), .bready_i(bready), .arvalid_i(arvalid), .arready_o(arready),
      .rvalid_o(rvalid), .rready_i(rready)
   );

endmodule

`default_nettype wire

// ==== dataRam.sv ====
`default_nettype none

module dataRam #(
   parameter int RAM_WORDS = 256
) (
   input  wire logic              gclk,
   input  wire logic              grst,
   input  wire aembDpPkg::axiBusT axiM_i,
   output aembDpPkg::axiBusT      axiS_o,
   input  wire logic              awvalid_i,
   output logic                   awready_o,
   input  wire logic              wvalid_i,
   output logic                   wready_o,
   output logic                   bvalid_o,
   input  wire logic              bready_i,
   input  wire logic              arvalid_i,
   output logic                   arready_o,
   output logic                   rvalid_o,
   input  wire logic              rready_i
);

   localparam int AW = $clog2(RAM_WORDS);

   aembDpPkg::busWordT mem [RAM_WORDS];

   logic               awGot;
   logic               wGot;
   logic [AW-1:0]      awIdxR;
   aembDpPkg::busWordT wDataR;
   logic [3:0]         wStrbR;
   aembDpPkg::busWordT rdataR;
   logic               awHs;
   logic               wHs;
   logic               arHs;
   logic               wrGo;
   logic [AW-1:0]      wrIdx;
   aembDpPkg::busWordT wrData;
   logic [3:0]         wrStrb;

   // one transaction at a time, so nothing is taken while a response waits
   assign awready_o = ~awGot & ~bvalid_o & ~rvalid_o;
   assign wready_o = ~wGot & ~bvalid_o & ~rvalid_o;
   assign arready_o = ~awGot & ~wGot & ~bvalid_o & ~rvalid_o;

   assign awHs = awvalid_i & awready_o;
   assign wHs = wvalid_i & wready_o;
   assign arHs = arvalid_i & arready_o;
   assign wrGo = (awGot | awHs) & (wGot | wHs);

   assign wrIdx = awGot ? awIdxR : axiM_i.awaddr[AW+1:2];
   assign wrData = wGot ? wDataR : axiM_i.wdata;
   assign wrStrb = wGot ? wStrbR : axiM_i.wstrb;

   always_ff @(posedge gclk) begin
      if (grst) begin
         awGot    <= 1'b0;
         wGot     <= 1'b0;
         bvalid_o <= 1'b0;
         rvalid_o <= 1'b0;
      end else begin
         if (wrGo) begin
            awGot    <= 1'b0;
            wGot     <= 1'b0;
            bvalid_o <= 1'b1;
         end else begin
            awGot <= awGot | awHs;
            wGot  <= wGot | wHs;
         end
         if (bvalid_o && bready_i) begin
            bvalid_o <= 1'b0;
         end
         if (arHs) begin
            rvalid_o <= 1'b1;
         end else if (rvalid_o && rready_i) begin
            rvalid_o <= 1'b0;
         end
      end
   end

   always_ff @(posedge gclk) begin
      if (awHs) begin
         awIdxR <= axiM_i.awaddr[AW+1:2];
      end
      if (wHs) begin
         wDataR <= axiM_i.wdata;
         wStrbR <= axiM_i.wstrb;
      end
      if (wrGo) begin
         for (int i = 0; i < 4; i++) begin
            if (wrStrb[i]) begin
               mem[wrIdx].b[i] <= wrData.b[i];
            end
         end
      end
      if (arHs) begin
         rdataR <= mem[axiM_i.araddr[AW+1:2]];
      end
   end

   assign axiS_o = '{awaddr: 32'd0, wdata: '0, wstrb: 4'd0, bresp: 2'b00,
                     araddr: 32'd0, rdata: rdataR, rresp: 2'b00};

endmodule

`default_nettype wire

// ==== axilMaster.sv ====
`default_nettype none

module axilMaster (
   input  wire logic               gclk,
   input  wire logic               grst,
   input  wire aembDpPkg::axiReqT  req_i,
   input  wire logic               reqValid_i,
   output logic                    reqReady_o,
   output logic                    done_o,
   output aembDpPkg::busWordT      rdata_o,
   output aembDpPkg::axiBusT       axiM_o,
   input  wire aembDpPkg::axiBusT  axiS_i,
   output logic                    awvalid_o,
   input  wire logic               awready_i,
   output logic                    wvalid_o,
   input  wire logic               wready_i,
   input  wire logic               bvalid_i,
   output logic                    bready_o,
   output logic                    arvalid_o,
   input  wire logic               arready_i,
   input  wire logic               rvalid_i,
   output logic                    rready_o
);

   logic              busy;
   aembDpPkg::axiReqT reqR;
   logic              start;
   logic              respHs;

   assign reqReady_o = ~busy;
   assign start = reqValid_i & ~busy;
   assign bready_o = 1'b1;
   assign rready_o = 1'b1;
   assign respHs = busy & ((bvalid_i & bready_o) | (rvalid_i & rready_o));

   always_ff @(posedge gclk) begin
      if (grst) begin
         busy      <= 1'b0;
         done_o    <= 1'b0;
         awvalid_o <= 1'b0;
         wvalid_o  <= 1'b0;
         arvalid_o <= 1'b0;
      end else begin
         done_o <= respHs;
         if (start) begin
            busy      <= 1'b1;
            awvalid_o <= req_i.write;
            wvalid_o  <= req_i.write;
            arvalid_o <= ~req_i.write;
         end
         if (awvalid_o && awready_i) begin
            awvalid_o <= 1'b0;   // aw and w may be taken on different edges
         end
         if (wvalid_o && wready_i) begin
            wvalid_o <= 1'b0;
         end
         if (arvalid_o && arready_i) begin
            arvalid_o <= 1'b0;
         end
         if (respHs) begin
            busy <= 1'b0;
         end
      end
   end

   always_ff @(posedge gclk) begin
      if (start) begin
         reqR <= req_i;
      end
      if (rvalid_i && rready_o) begin
         rdata_o <= axiS_i.rdata;
      end
   end

   assign axiM_o = '{awaddr: reqR.addr, wdata: reqR.wdata, wstrb: reqR.wstrb, bresp: 2'b00,
                     araddr: reqR.addr, rdata: '0, rresp: 2'b00};

endmodule

`default_nettype wire

// ==== memStage.sv ====
`default_nettype none

module memStage #(
   parameter int RAM_WORDS = 256
) (
   input  wire logic               gclk,
   input  wire logic               grst,
   input  wire aembDpPkg::cmdT     cmd_i,
   input  wire logic               cmdValid_i,
   output logic                    cmdReady_o,
   output logic                    wEn_o,
   output logic [4:0]              wAddr_o,
   output aembDpPkg::wbSelT        wbSel_o,
   output logic [31:0]             result_o,
   output logic [31:2]             pcLink_o,
   output logic [3:0]              dwbSel_o,
   output logic [4:0]              stAddr_o,
   output aembDpPkg::sizeT         size_o,
   output logic                    gena_o,
   input  wire aembDpPkg::busWordT storeData_i,
   output aembDpPkg::axiReqT       req_o,
   output logic                    reqValid_o,
   input  wire logic               reqReady_i,
   input  wire logic               done_i
);

   typedef enum logic [2:0] {CLEAR, IDLE, WB, STORE_WAIT, LOAD_WAIT} stateT;

   stateT            state;
   logic [4:0]       clrCnt;
   logic             wEnR;
   logic [4:0]       wAddrR;
   aembDpPkg::wbSelT wbSelR;
   logic [31:0]      resultR;
   logic [3:0]       dwbSelR;
   logic [31:0]      reqAddrR;
   logic             reqWriteR;
   logic [3:0]       byteSel;
   logic             accept;

   assign cmdReady_o = (state == IDLE) || (state == WB);
   assign accept = cmdValid_i & cmdReady_o;

   // lane for loads, strobe for stores; misaligned low bits are dropped
   always_comb begin
      case (cmd_i.size)
         aembDpPkg::SZ_BYTE: byteSel = 4'b0001 << cmd_i.value[1:0];
         aembDpPkg::SZ_HALF: byteSel = cmd_i.value[1] ? 4'b1100 : 4'b0011;
         default:            byteSel = 4'b1111;
      endcase
   end

   always_ff @(posedge gclk) begin
      if (grst) begin
         state      <= CLEAR;
         clrCnt     <= 5'd0;
         wEnR       <= 1'b0;
         reqValid_o <= 1'b0;
      end else begin
         wEnR <= 1'b0;
         if (reqValid_o && reqReady_i) begin
            reqValid_o <= 1'b0;
         end
         case (state)
            CLEAR: begin
               wEnR   <= 1'b1;   // bank drops the r0 slot of the sweep
               clrCnt <= clrCnt + 5'd1;
               if (clrCnt == 5'd31) begin
                  state <= IDLE;
               end
            end
            IDLE, WB: begin
               state <= IDLE;
               if (accept) begin
                  case (cmd_i.op)
                     aembDpPkg::OP_LOAD: begin
                        state      <= LOAD_WAIT;
                        reqValid_o <= 1'b1;
                     end
                     aembDpPkg::OP_STORE: begin
                        state      <= STORE_WAIT;
                        reqValid_o <= 1'b1;
                     end
                     default: begin
                        state <= WB;
                        wEnR  <= 1'b1;
                     end
                  endcase
               end
            end
            default: begin
               if (done_i) begin
                  state <= IDLE;
               end
            end
         endcase
      end
   end

   always_ff @(posedge gclk) begin
      if (state == CLEAR) begin
         wAddrR  <= clrCnt;
         wbSelR  <= aembDpPkg::WB_RESULT;
         resultR <= 32'd0;
      end else if (accept) begin
         wAddrR    <= cmd_i.rd;
         resultR   <= cmd_i.value;
         dwbSelR   <= byteSel;
         reqWriteR <= (cmd_i.op == aembDpPkg::OP_STORE);
         reqAddrR  <= {cmd_i.value[31:2] & 30'(RAM_WORDS - 1), 2'b00};
         case (cmd_i.op)
            aembDpPkg::OP_LINK: wbSelR <= aembDpPkg::WB_LINK;
            aembDpPkg::OP_LOAD: wbSelR <= aembDpPkg::WB_LOAD;
            default:            wbSelR <= aembDpPkg::WB_RESULT;
         endcase
      end
   end

   // a load commits on the edge that ends its wait
   assign wEn_o = wEnR | ((state == LOAD_WAIT) & done_i);
   assign wAddr_o = wAddrR;
   assign wbSel_o = wbSelR;
   assign result_o = resultR;
   assign pcLink_o = resultR[31:2];
   assign dwbSel_o = dwbSelR;

   // store source is read as the command is taken
   assign stAddr_o = cmd_i.rd;
   assign size_o = cmd_i.size;
   assign gena_o = accept & (cmd_i.op == aembDpPkg::OP_STORE);

   assign req_o = '{addr: reqAddrR, wdata: storeData_i, wstrb: dwbSelR, write: reqWriteR};

endmodule

`default_nettype wire

// ==== regBank.sv ====
`default_nettype none

module regBank (
   input  wire logic               gclk,
   input  wire logic               grst,
   input  wire logic               gena_i,
   input  wire logic               wEn_i,
   input  wire logic [4:0]         wAddr_i,
   input  wire aembDpPkg::wbSelT   wbSel_i,
   input  wire logic [31:0]        result_i,
   input  wire logic [31:2]        pcLink_i,
   input  wire aembDpPkg::busWordT busRd_i,
   input  wire logic [3:0]         dwbSel_i,
   input  wire aembDpPkg::sizeT    size_i,
   input  wire logic [4:0]         stAddr_i,
   input  wire logic [4:0]         rdAddr_i,
   output logic [31:0]             rdData_o,
   output aembDpPkg::busWordT      storeData_o
);

   logic [31:0] aView [32];   // external read port
   logic [31:0] sView [32];   // store source port
   logic [31:0] wView [32];   // write-back port

   logic [31:0]        loadAl;
   logic [31:0]        xWdat;
   logic [31:0]        wbOld;
   logic [31:0]        stSrc;
   logic               wrOk;
   logic               fwd;
   aembDpPkg::busWordT xSt;

   assign wrOk = wEn_i & (wAddr_i != 5'd0);   // r0 is never written
   assign wbOld = wView[wAddr_i];

   always_comb begin
      case (dwbSel_i)
         4'b0001: loadAl = {24'd0, busRd_i.b[0]};
         4'b0010: loadAl = {24'd0, busRd_i.b[1]};
         4'b0100: loadAl = {24'd0, busRd_i.b[2]};
         4'b1000: loadAl = {24'd0, busRd_i.b[3]};
         4'b0011: loadAl = {16'd0, busRd_i.h[0]};
         4'b1100: loadAl = {16'd0, busRd_i.h[1]};
         default: loadAl = busRd_i;
      endcase
   end

   always_comb begin
      case (wbSel_i)
         aembDpPkg::WB_RESULT: xWdat = result_i;
         aembDpPkg::WB_LINK:   xWdat = {pcLink_i, 2'b00};
         aembDpPkg::WB_LOAD:   xWdat = loadAl;
         default:              xWdat = wbOld;   // spare code keeps the old contents
      endcase
   end

   always_ff @(posedge gclk) begin
      if (wrOk) begin
         aView[wAddr_i] <= xWdat;
         sView[wAddr_i] <= xWdat;
         wView[wAddr_i] <= xWdat;
      end
   end

   assign rdData_o = (rdAddr_i == 5'd0) ? 32'd0 : aView[rdAddr_i];

   // a store launched on the commit edge would read the stale copy
   assign fwd = wrOk & (wAddr_i == stAddr_i) & (wbSel_i != aembDpPkg::WB_LOAD);

   always_comb begin
      if (fwd) begin
         stSrc = xWdat;
      end else if (stAddr_i == 5'd0) begin
         stSrc = 32'd0;
      end else begin
         stSrc = sView[stAddr_i];
      end
   end

   always_comb begin
      case (size_i)
         aembDpPkg::SZ_BYTE: xSt.b = {4{stSrc[7:0]}};
         aembDpPkg::SZ_HALF: xSt.h = {2{stSrc[15:0]}};
         default:            xSt = stSrc;
      endcase
   end

   always_ff @(posedge gclk) begin
      if (grst) begin
         storeData_o <= '0;
      end else if (gena_i) begin
         storeData_o <= xSt;   // held until the master takes the request
      end
   end

endmodule

`default_nettype wire

// ==== aembDpPkg.sv ====
`default_nettype none

package aembDpPkg;

   typedef enum logic [1:0] {
      OP_ALU,
      OP_LINK,
      OP_LOAD,
      OP_STORE
   } opT;

   typedef enum logic [1:0] {
      SZ_BYTE,
      SZ_HALF,
      SZ_WORD
   } sizeT;

   typedef enum logic [1:0] {
      WB_RESULT,
      WB_LINK,
      WB_LOAD
   } wbSelT;

   typedef struct packed {
      opT          op;
      sizeT        size;
      logic [4:0]  rd;      // destination, or source register of a store
      logic [31:0] value;   // ALU result, link PC or byte address
   } cmdT;

   // one bus word, seen as byte lanes or halfword lanes
   typedef union packed {
      logic [3:0][7:0]  b;
      logic [1:0][15:0] h;
   } busWordT;

   typedef struct packed {
      logic [31:0] addr;
      logic [31:0] wdata;
      logic [3:0]  wstrb;
      logic        write;
   } axiReqT;

   typedef struct packed {
      logic [31:0] awaddr;
      busWordT     wdata;
      logic [3:0]  wstrb;
      logic [1:0]  bresp;
      logic [31:0] araddr;
      busWordT     rdata;
      logic [1:0]  rresp;
   } axiBusT;

endpackage

`default_nettype wire
